// File: include/alu_params.svh
// Word size, trit encodings and opcode codes for the ternary ALU
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// Word geometry
`define WORD_TRITS   9
`define TRIT_BITS    2
`define OPCODE_BITS  6

// Trit encodings, the pattern 2'b10 is illegal and reads as zero
`define TRIT_NEG     2'b11
`define TRIT_ZERO    2'b00
`define TRIT_POS     2'b01

// Opcodes, each one is three legal trits
`define ALU_OP_NOT   6'b000001
`define ALU_OP_AND   6'b000011
`define ALU_OP_OR    6'b000100
`define ALU_OP_XOR   6'b000101
`define ALU_OP_ADD   6'b000111
`define ALU_OP_SUB   6'b001100
`define ALU_OP_LT    6'b001101
`define ALU_OP_EQ    6'b001111

`endif

// File: source/trit_pkg.sv
// Trit and word vector types with trit normalization and negation helpers
`include "alu_params.svh"

package trit_pkg;

    // One balanced-ternary digit
    typedef logic [`TRIT_BITS-1:0] trit_t;

    // Trit i sits in bits 2i+1:2i, trit 0 is least significant
    typedef logic [`WORD_TRITS*`TRIT_BITS-1:0] word_t;

    // Illegal code reads as zero
    function automatic trit_t trit_norm(input trit_t t);
        return (t == 2'b10) ? trit_t'(`TRIT_ZERO) : t;
    endfunction

    function automatic trit_t trit_neg(input trit_t t);
        case (trit_norm(t))
            `TRIT_POS: return `TRIT_NEG;
            `TRIT_NEG: return `TRIT_POS;
            default:   return `TRIT_ZERO;
        endcase
    endfunction

endpackage

// File: source/alu_pkg.sv
// Opcode type and the issue struct passed from decode to execute
`include "alu_params.svh"

package alu_pkg;

    // Three trits of opcode
    typedef logic [`OPCODE_BITS-1:0] opcode_t;

    // One operation as registered by the decode stage
    typedef struct packed {
        opcode_t         op;
        trit_pkg::word_t operand_a;
        trit_pkg::word_t operand_b;
    } alu_issue_t;

endpackage

// File: source/trit_logic_unit.sv
// Trit-wise NOT, AND (minimum), OR (maximum) and XOR over a 9-trit word
`timescale 1ns/100ps
`include "alu_params.svh"

module trit_logic_unit (
    input  trit_pkg::word_t a,
    input  trit_pkg::word_t b,
    output trit_pkg::word_t not_out,
    output trit_pkg::word_t and_out,
    output trit_pkg::word_t or_out,
    output trit_pkg::word_t xor_out
);

    // Minimum, a -1 on either side wins
    function automatic trit_pkg::trit_t trit_min(input trit_pkg::trit_t x, y);
        if (x == `TRIT_NEG || y == `TRIT_NEG) begin
            return `TRIT_NEG;
        end
        return (x == `TRIT_POS && y == `TRIT_POS) ? `TRIT_POS : `TRIT_ZERO;
    endfunction

    // Maximum, a +1 on either side wins
    function automatic trit_pkg::trit_t trit_max(input trit_pkg::trit_t x, y);
        if (x == `TRIT_POS || y == `TRIT_POS) begin
            return `TRIT_POS;
        end
        return (x == `TRIT_NEG && y == `TRIT_NEG) ? `TRIT_NEG : `TRIT_ZERO;
    endfunction

    // Opposite signs cancel, two equal nonzero trits flip to -1
    function automatic trit_pkg::trit_t trit_xor(input trit_pkg::trit_t x, y);
        case ({x, y})
            {`TRIT_NEG,  `TRIT_NEG},  {`TRIT_NEG,  `TRIT_ZERO},
            {`TRIT_ZERO, `TRIT_NEG},  {`TRIT_POS,  `TRIT_POS}:  return `TRIT_NEG;
            {`TRIT_ZERO, `TRIT_POS},  {`TRIT_POS,  `TRIT_ZERO}: return `TRIT_POS;
            default:                                           return `TRIT_ZERO;
        endcase
    endfunction

    always_comb begin
        trit_pkg::trit_t ta;
        trit_pkg::trit_t tb;

        for (int i = 0; i < `WORD_TRITS; i++) begin
            ta = trit_pkg::trit_norm(a[`TRIT_BITS*i +: `TRIT_BITS]);
            tb = trit_pkg::trit_norm(b[`TRIT_BITS*i +: `TRIT_BITS]);
            // NOT is unary on a
            not_out[`TRIT_BITS*i +: `TRIT_BITS] = trit_pkg::trit_neg(ta);
            and_out[`TRIT_BITS*i +: `TRIT_BITS] = trit_min(ta, tb);
            or_out[`TRIT_BITS*i +: `TRIT_BITS]  = trit_max(ta, tb);
            xor_out[`TRIT_BITS*i +: `TRIT_BITS] = trit_xor(ta, tb);
        end
    end

endmodule

// File: source/trit_ripple_adder.sv
// Balanced-ternary 9-trit ripple-carry adder with optional negation of b
`timescale 1ns/100ps
`include "alu_params.svh"

module trit_ripple_adder (
    input  trit_pkg::word_t a,
    input  trit_pkg::word_t b,
    input  logic            negate_b,
    output trit_pkg::word_t sum
);

    // Any rule: zero yields the other trit, opposite signs cancel
    function automatic trit_pkg::trit_t trit_any(input trit_pkg::trit_t x, y);
        if (x == `TRIT_ZERO) begin
            return y;
        end
        if (y == `TRIT_ZERO) begin
            return x;
        end
        return (x == y) ? x : `TRIT_ZERO;
    endfunction

    // Consensus rule: nonzero only when both agree
    function automatic trit_pkg::trit_t trit_cons(input trit_pkg::trit_t x, y);
        return (x == y) ? x : `TRIT_ZERO;
    endfunction

    // Half-add sum digit built from the any and consensus rules
    function automatic trit_pkg::trit_t half_sum(input trit_pkg::trit_t x, y);
        trit_pkg::trit_t cons_neg;

        cons_neg = trit_pkg::trit_neg(trit_cons(x, y));
        return trit_any(cons_neg, trit_any(cons_neg, trit_any(x, y)));
    endfunction

    always_comb begin
        trit_pkg::trit_t ta;
        trit_pkg::trit_t tb;
        trit_pkg::trit_t part;
        trit_pkg::trit_t carry1;
        trit_pkg::trit_t carry2;
        trit_pkg::trit_t carry;

        carry = `TRIT_ZERO;
        for (int i = 0; i < `WORD_TRITS; i++) begin
            ta = trit_pkg::trit_norm(a[`TRIT_BITS*i +: `TRIT_BITS]);
            tb = trit_pkg::trit_norm(b[`TRIT_BITS*i +: `TRIT_BITS]);
            if (negate_b) begin
                tb = trit_pkg::trit_neg(tb);
            end
            // b plus carry first, then a plus the partial sum
            part   = half_sum(tb, carry);
            carry1 = trit_cons(tb, carry);
            sum[`TRIT_BITS*i +: `TRIT_BITS] = half_sum(ta, part);
            carry2 = trit_cons(ta, part);
            carry  = trit_any(carry1, carry2);
        end
        // Carry out of trit 8 is dropped, so the sum wraps modulo 3^9
    end

endmodule

// File: source/trit_comparator.sv
// Signed less-than and equality of two balanced-ternary words, MSB first
`timescale 1ns/100ps
`include "alu_params.svh"

module trit_comparator (
    input  trit_pkg::word_t a,
    input  trit_pkg::word_t b,
    output logic            lt,
    output logic            eq
);

    // Digit order is -1 < 0 < +1
    function automatic logic trit_less(input trit_pkg::trit_t x, y);
        return (x == `TRIT_NEG && y != `TRIT_NEG) ||
               (x == `TRIT_ZERO && y == `TRIT_POS);
    endfunction

    always_comb begin
        trit_pkg::trit_t ta;
        trit_pkg::trit_t tb;
        logic            lt_chain;
        logic            eq_chain;

        lt_chain = 1'b0;
        eq_chain = 1'b1;
        // The first differing trit from the top decides
        for (int i = `WORD_TRITS - 1; i >= 0; i--) begin
            ta = trit_pkg::trit_norm(a[`TRIT_BITS*i +: `TRIT_BITS]);
            tb = trit_pkg::trit_norm(b[`TRIT_BITS*i +: `TRIT_BITS]);
            lt_chain = lt_chain | (eq_chain & trit_less(ta, tb));
            eq_chain = eq_chain & (ta == tb);
        end
        lt = lt_chain;
        eq = eq_chain;
    end

endmodule

// File: source/alu_decode_stage.sv
// First pipeline stage, registers opcode and operands into the issue struct
`timescale 1ns/100ps
`include "alu_params.svh"

module alu_decode_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en,
    input  alu_pkg::opcode_t     op,
    input  trit_pkg::word_t      operand_a,
    input  trit_pkg::word_t      operand_b,
    output alu_pkg::alu_issue_t  issue,
    output logic                 issue_valid
);

    logic illegal_trit;

    // Flag any operand trit carrying the unused 2'b10 code
    always_comb begin
        illegal_trit = 1'b0;
        for (int i = 0; i < `WORD_TRITS; i++) begin
            if (trit_pkg::trit_norm(operand_a[`TRIT_BITS*i +: `TRIT_BITS]) !=
                operand_a[`TRIT_BITS*i +: `TRIT_BITS]) begin
                illegal_trit = 1'b1;
            end
            if (trit_pkg::trit_norm(operand_b[`TRIT_BITS*i +: `TRIT_BITS]) !=
                operand_b[`TRIT_BITS*i +: `TRIT_BITS]) begin
                illegal_trit = 1'b1;
            end
        end
    end

    // Payload holds while en is low, valid follows en
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue       <= '0;
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= en;
            if (en) begin
                issue.op        <= op;
                issue.operand_a <= operand_a;
                issue.operand_b <= operand_b;
            end
        end
    end

    // Operands from the source must use legal trit codes only
    a_legal_operands: assert property (
        @(posedge clk) disable iff (!rst_n)
        en |-> !illegal_trit
    ) else $error("illegal trit code on an issued operand");

endmodule

// File: source/alu_execute_stage.sv
// Second pipeline stage that runs the trit units and registers the selected result
`timescale 1ns/100ps
`include "alu_params.svh"

module alu_execute_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  alu_pkg::alu_issue_t  issue,
    input  logic                 issue_valid,
    output trit_pkg::word_t      result,
    output logic                 result_valid
);

    trit_pkg::word_t not_word;
    trit_pkg::word_t and_word;
    trit_pkg::word_t or_word;
    trit_pkg::word_t xor_word;
    trit_pkg::word_t sum_word;
    trit_pkg::word_t flag_lt;
    trit_pkg::word_t flag_eq;
    trit_pkg::word_t result_next;
    logic            negate_b;
    logic            a_lt_b;
    logic            a_eq_b;

    // SUB reuses the adder with b negated
    assign negate_b = (issue.op == `ALU_OP_SUB);

    trit_logic_unit logic_i (
        .a       (issue.operand_a),
        .b       (issue.operand_b),
        .not_out (not_word),
        .and_out (and_word),
        .or_out  (or_word),
        .xor_out (xor_word)
    );

    trit_ripple_adder adder_i (
        .a        (issue.operand_a),
        .b        (issue.operand_b),
        .negate_b (negate_b),
        .sum      (sum_word)
    );

    trit_comparator cmp_i (
        .a  (issue.operand_a),
        .b  (issue.operand_b),
        .lt (a_lt_b),
        .eq (a_eq_b)
    );

    // Comparison results land in trit 0 as +1 or 0
    assign flag_lt = {{(`WORD_TRITS-1){`TRIT_ZERO}}, (a_lt_b ? `TRIT_POS : `TRIT_ZERO)};
    assign flag_eq = {{(`WORD_TRITS-1){`TRIT_ZERO}}, (a_eq_b ? `TRIT_POS : `TRIT_ZERO)};

    always_comb begin
        case (issue.op)
            `ALU_OP_NOT: result_next = not_word;
            `ALU_OP_AND: result_next = and_word;
            `ALU_OP_OR:  result_next = or_word;
            `ALU_OP_XOR: result_next = xor_word;
            `ALU_OP_ADD,
            `ALU_OP_SUB: result_next = sum_word;
            `ALU_OP_LT:  result_next = flag_lt;
            `ALU_OP_EQ:  result_next = flag_eq;
            default:     result_next = issue.operand_a;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= issue_valid;
            if (issue_valid) begin
                result <= result_next;
            end
        end
    end

    // The comparator never reports less-than and equal together
    a_cmp_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue_valid |-> !(a_lt_b && a_eq_b)
    ) else $error("comparator reports less-than and equal at once");

    // Subtracting equal operands gives all zero trits
    a_sub_equal_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue_valid && negate_b && a_eq_b |-> sum_word == '0
    ) else $error("SUB of equal operands is not zero");

endmodule

// File: source/ternary_alu_top.sv
// Top level of the two-stage balanced-ternary ALU pipeline
`timescale 1ns/100ps

module ternary_alu_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             en,
    input  alu_pkg::opcode_t op,
    input  trit_pkg::word_t  operand_a,
    input  trit_pkg::word_t  operand_b,
    output trit_pkg::word_t  result,
    output logic             result_valid
);

    alu_pkg::alu_issue_t issue;
    logic                issue_valid;

    alu_decode_stage decode_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .op          (op),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .issue       (issue),
        .issue_valid (issue_valid)
    );

    // Result appears two edges after the operation is sampled
    alu_execute_stage execute_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue        (issue),
        .issue_valid  (issue_valid),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

// File: verification/ternary_alu_tb.sv
// Directed testbench for the ternary ALU with reference model, checker and timeout
`timescale 1ns/100ps
`include "alu_params.svh"

module ternary_alu_tb;

    localparam int WORD_MAX       = 9841;
    localparam int WORD_RANGE     = 19683;
    localparam int RESET_CYCLES   = 8;
    localparam int MAX_LATENCY    = 8;
    localparam int RANDOM_PAIRS   = 40;
    localparam int CMP_PAIRS      = 10;
    // Operations issued by the logic, arithmetic, compare and unknown-opcode tests
    localparam int NUM_OPS        = 36 + 2 * (RANDOM_PAIRS + 6) + 2 * 4 * CMP_PAIRS + 4;
    localparam int OP_CYCLES      = 3;
    localparam int TEST_CYCLES    = RESET_CYCLES + 4 + NUM_OPS * OP_CYCLES + 16;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 100;

    // XOR result indexed by 3*(a+1) + (b+1)
    localparam int XOR_TABLE [9] = '{-1, -1, 0, -1, 0, 1, 0, 1, -1};
    localparam alu_pkg::opcode_t LOGIC_OPS [4] =
        '{`ALU_OP_NOT, `ALU_OP_AND, `ALU_OP_OR, `ALU_OP_XOR};
    localparam alu_pkg::opcode_t MIXED_OPS [8] = '{`ALU_OP_ADD, `ALU_OP_SUB, `ALU_OP_XOR,
        `ALU_OP_LT, `ALU_OP_AND, `ALU_OP_EQ, `ALU_OP_OR, `ALU_OP_NOT};
    localparam alu_pkg::opcode_t UNKNOWN_OPS [4] = '{6'b000000, 6'b010001, 6'b110011, 6'b111111};
    localparam int EDGE_A [6] = '{WORD_MAX, -WORD_MAX, WORD_MAX, -WORD_MAX, WORD_MAX, -WORD_MAX};
    localparam int EDGE_B [6] = '{WORD_MAX, -WORD_MAX, -WORD_MAX, WORD_MAX, 1, -1};
    // Bit k set means an operation is issued in cycle k of the back-to-back test
    localparam logic [11:0] ISSUE_PATTERN = 12'b0010_1100_1111;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             en;
    alu_pkg::opcode_t op;
    trit_pkg::word_t  operand_a;
    trit_pkg::word_t  operand_b;
    trit_pkg::word_t  result;
    logic             result_valid;

    logic [31:0] lfsr_state  = 32'd42;
    int          cycle_count = 0;

    ternary_alu_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .op           (op),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .result       (result),
        .result_valid (result_valid)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("Test failures found");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic fail_run(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        $display("Test failures found");
        $fatal(1, "stopping at the first error");
    endtask

    // Galois LFSR stepped once per bit
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic trit_pkg::trit_t random_trit();
        trit_pkg::trit_t code;
        code = 2'b10;
        // The unused code is drawn again
        while (code == 2'b10) begin
            code[1] = lfsr_bit();
            code[0] = lfsr_bit();
        end
        return code;
    endfunction

    function automatic trit_pkg::word_t random_word();
        trit_pkg::word_t w;
        for (int i = 0; i < `WORD_TRITS; i++) begin
            w[`TRIT_BITS*i +: `TRIT_BITS] = random_trit();
        end
        return w;
    endfunction

    function automatic int trit_val(input trit_pkg::trit_t t);
        case (t)
            `TRIT_POS: return 1;
            `TRIT_NEG: return -1;
            default:   return 0;
        endcase
    endfunction

    function automatic trit_pkg::trit_t trit_code(input int v);
        if (v > 0) begin
            return `TRIT_POS;
        end
        return (v < 0) ? `TRIT_NEG : `TRIT_ZERO;
    endfunction

    function automatic int word_to_int(input trit_pkg::word_t w);
        int sum;
        int weight;
        sum = 0;
        weight = 1;
        for (int i = 0; i < `WORD_TRITS; i++) begin
            sum = sum + trit_val(w[`TRIT_BITS*i +: `TRIT_BITS]) * weight;
            weight = weight * 3;
        end
        return sum;
    endfunction

    // Balanced digits from the remainder where 2 becomes -1 with a borrow
    function automatic trit_pkg::word_t int_to_word(input int value);
        trit_pkg::word_t w;
        int v;
        int r;
        v = value;
        w = '0;
        for (int i = 0; i < `WORD_TRITS; i++) begin
            r = ((v % 3) + 3) % 3;
            if (r == 2) begin
                w[`TRIT_BITS*i +: `TRIT_BITS] = `TRIT_NEG;
                v = (v + 1) / 3;
            end else if (r == 1) begin
                w[`TRIT_BITS*i +: `TRIT_BITS] = `TRIT_POS;
                v = (v - 1) / 3;
            end else begin
                v = v / 3;
            end
        end
        return w;
    endfunction

    function automatic int wrap_value(input int v);
        return ((v + WORD_MAX) % WORD_RANGE + WORD_RANGE) % WORD_RANGE - WORD_MAX;
    endfunction

    function automatic trit_pkg::word_t logic_ref(input alu_pkg::opcode_t op_in,
                                                  input trit_pkg::word_t a, b);
        trit_pkg::word_t w;
        int x;
        int y;
        int r;
        for (int i = 0; i < `WORD_TRITS; i++) begin
            x = trit_val(a[`TRIT_BITS*i +: `TRIT_BITS]);
            y = trit_val(b[`TRIT_BITS*i +: `TRIT_BITS]);
            if (op_in == `ALU_OP_NOT) begin
                r = -x;
            end else if (op_in == `ALU_OP_AND) begin
                r = (x < y) ? x : y;
            end else if (op_in == `ALU_OP_OR) begin
                r = (x > y) ? x : y;
            end else begin
                r = XOR_TABLE[3 * (x + 1) + (y + 1)];
            end
            w[`TRIT_BITS*i +: `TRIT_BITS] = trit_code(r);
        end
        return w;
    endfunction

    function automatic trit_pkg::word_t model_result(input alu_pkg::opcode_t op_in,
                                                     input trit_pkg::word_t a, b);
        case (op_in)
            `ALU_OP_NOT, `ALU_OP_AND, `ALU_OP_OR, `ALU_OP_XOR: return logic_ref(op_in, a, b);
            `ALU_OP_ADD: return int_to_word(wrap_value(word_to_int(a) + word_to_int(b)));
            `ALU_OP_SUB: return int_to_word(wrap_value(word_to_int(a) - word_to_int(b)));
            `ALU_OP_LT:  return int_to_word((word_to_int(a) < word_to_int(b)) ? 1 : 0);
            `ALU_OP_EQ:  return int_to_word((word_to_int(a) == word_to_int(b)) ? 1 : 0);
            default:     return a;
        endcase
    endfunction

    // Issue one operation at a falling edge and wait for its result
    task automatic run_op(input alu_pkg::opcode_t op_in, input trit_pkg::word_t a, b);
        trit_pkg::word_t expected;
        int edges;
        expected = model_result(op_in, a, b);
        en = 1'b1;
        op = op_in;
        operand_a = a;
        operand_b = b;
        edges = 0;
        do begin
            @(negedge clk);
            en = 1'b0;
            edges++;
        end while (!result_valid && edges < MAX_LATENCY);
        if (!result_valid) begin
            fail_run("result_valid never rose after an issued operation");
        end
        check_equal(32'(edges), 32'd2, "rising edges from issue to result");
        check_equal(32'(result), 32'(expected), $sformatf("op %b a %h b %h", op_in, a, b));
    endtask

    task automatic idle_after_reset();
        repeat (4) begin
            @(negedge clk);
            check_equal(32'(result_valid), 32'd0, "result_valid before any issue");
            check_equal(32'(result), 32'd0, "result before any issue");
        end
    endtask

    // Each word holds all nine pairs and rotates so every pair visits every position
    task automatic logic_op_sweep();
        trit_pkg::word_t a;
        trit_pkg::word_t b;
        int pair;
        for (int o = 0; o < 4; o++) begin
            for (int rot = 0; rot < 9; rot++) begin
                for (int pos = 0; pos < `WORD_TRITS; pos++) begin
                    pair = (pos + rot) % 9;
                    a[`TRIT_BITS*pos +: `TRIT_BITS] = trit_code(pair / 3 - 1);
                    b[`TRIT_BITS*pos +: `TRIT_BITS] = trit_code(pair % 3 - 1);
                end
                run_op(LOGIC_OPS[o], a, b);
            end
        end
    endtask

    task automatic add_sub_cases();
        trit_pkg::word_t a;
        trit_pkg::word_t b;
        for (int n = 0; n < 6 + RANDOM_PAIRS; n++) begin
            if (n < 6) begin
                a = int_to_word(EDGE_A[n]);
                b = int_to_word(EDGE_B[n]);
            end else begin
                a = random_word();
                b = random_word();
            end
            run_op(`ALU_OP_ADD, a, b);
            run_op(`ALU_OP_SUB, a, b);
        end
    endtask

    task automatic compare_cases();
        trit_pkg::word_t a;
        trit_pkg::word_t b;
        for (int n = 0; n < 4 * CMP_PAIRS; n++) begin
            a = random_word();
            b = (n < 2 * CMP_PAIRS) ? random_word() : a;
            // Last group differs from a in trit 0 only
            if (n >= 3 * CMP_PAIRS) begin
                b[`TRIT_BITS-1:0] = trit_code((trit_val(a[`TRIT_BITS-1:0]) + 2) % 3 - 1);
            end
            run_op(`ALU_OP_LT, a, b);
            run_op(`ALU_OP_EQ, a, b);
        end
    endtask

    task automatic back_to_back_issue();
        trit_pkg::word_t  expected_q[$];
        trit_pkg::word_t  held;
        trit_pkg::word_t  a;
        trit_pkg::word_t  b;
        alu_pkg::opcode_t next_op;
        logic             want_valid;
        int               issued;
        issued = 0;
        @(negedge clk);
        held = result;
        for (int k = 0; k < 14; k++) begin
            want_valid = (k >= 2) ? ISSUE_PATTERN[k-2] : 1'b0;
            check_equal(32'(result_valid), 32'(want_valid), $sformatf("valid in cycle %0d", k));
            if (want_valid) begin
                check_equal(32'(result), 32'(expected_q.pop_front()), "result order");
                held = result;
            end else begin
                check_equal(32'(result), 32'(held), "result held during a gap");
            end
            en = 1'b0;
            if (k < 12) begin
                if (ISSUE_PATTERN[k]) begin
                    next_op = MIXED_OPS[issued % 8];
                    a = random_word();
                    b = random_word();
                    expected_q.push_back(model_result(next_op, a, b));
                    en = 1'b1;
                    op = next_op;
                    operand_a = a;
                    operand_b = b;
                    issued++;
                end
            end
            @(negedge clk);
        end
        check_equal(32'(expected_q.size()), 32'd0, "results left outstanding");
    endtask

    task automatic unknown_op_passthrough();
        for (int n = 0; n < 4; n++) begin
            run_op(UNKNOWN_OPS[n], random_word(), random_word());
        end
    endtask

    initial begin
        rst_n = 1'b0;
        en = 1'b0;
        op = '0;
        operand_a = '0;
        operand_b = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        idle_after_reset();
        logic_op_sweep();
        add_sub_cases();
        compare_cases();
        back_to_back_issue();
        unknown_op_passthrough();
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
source/trit_pkg.sv
source/alu_pkg.sv
source/trit_logic_unit.sv
source/trit_ripple_adder.sv
source/trit_comparator.sv
source/alu_decode_stage.sv
source/alu_execute_stage.sv
source/ternary_alu_top.sv
verification/ternary_alu_tb.sv

// File: Makefile
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vlog.f --top-module ternary_alu_tb --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vternary_alu_tb | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
